//--- include/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// byte address of a fetch
`define ICACHE_ADDR_WIDTH 32

// geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 16
`define ICACHE_LINE_WORDS 8

// largest block a fetch request may ask for
`define ICACHE_FETCH_WORDS 8

`define ICACHE_SET_BITS 4
`define ICACHE_WORD_BITS 3
`define ICACHE_TAG_BITS 23 // addr minus set, word and byte bits

`endif

//--- hdl/icache_pkg.sv
`include "icache_settings.svh"

package icache_pkg;

    // physical fetch address split into cache fields
    typedef struct packed {
        logic [`ICACHE_TAG_BITS-1:0]  tag;
        logic [`ICACHE_SET_BITS-1:0]  set;
        logic [`ICACHE_WORD_BITS-1:0] word;   // start word within the line
        logic [1:0]                   byte_off;
    } fetch_addr_t;

    typedef union packed {
        logic [`ICACHE_ADDR_WIDTH-1:0] raw;
        fetch_addr_t                   f;
    } fetch_addr_u;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,    // burst address pending on the memory port
        REFILL
    } cache_state_t;

endpackage

//--- hdl/icache_way_if.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

interface icache_way_if;
    logic                                                rd_en;
    logic [1:0][`ICACHE_SET_BITS-1:0]                    tag_index;  // set and set+1
    logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_SET_BITS-1:0] bank_index; // one set per bank
    logic                                                we;
    logic [`ICACHE_SET_BITS-1:0]                         windex;
    logic [`ICACHE_TAG_BITS-1:0]                         wtag;
    logic [`ICACHE_LINE_WORDS-1:0][31:0]                 wline;
    logic [1:0][`ICACHE_TAG_BITS:0]                      tagv;       // {valid, tag}
    logic [`ICACHE_LINE_WORDS-1:0][31:0]                 rdata;

    modport ctrl (
        output rd_en,
        output tag_index,
        output bank_index,
        output we,
        output windex,
        output wtag,
        output wline,
        input  tagv,
        input  rdata
    );

    modport way (
        input  rd_en,
        input  tag_index,
        input  bank_index,
        input  we,
        input  windex,
        input  wtag,
        input  wline,
        output tagv,
        output rdata
    );
endinterface

//--- hdl/icache_way.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_way (
    input logic        clk,
    input logic        reset,
    icache_way_if.way  way
);
    logic [`ICACHE_SETS-1:0]      valid;
    logic [`ICACHE_TAG_BITS-1:0]  tag_mem [`ICACHE_SETS];
    logic [31:0]                  data_mem [`ICACHE_LINE_WORDS][`ICACHE_SETS]; // one bank per word

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
        end else if (way.we) begin
            valid[way.windex] <= 1'b1;
        end
    end

    // tag side, both candidate sets read together
    always_ff @(posedge clk) begin
        if (way.we) begin
            tag_mem[way.windex] <= way.wtag;
        end
        if (way.rd_en) begin
            for (int k = 0; k < 2; k++) begin
                way.tagv[k] <= {valid[way.tag_index[k]], tag_mem[way.tag_index[k]]};
            end
        end
    end

    // each bank takes its own index so a read can straddle two lines
    always_ff @(posedge clk) begin
        for (int j = 0; j < `ICACHE_LINE_WORDS; j++) begin
            if (way.we) begin
                data_mem[j][way.windex] <= way.wline[j];
            end
            if (way.rd_en) begin
                way.rdata[j] <= data_mem[j][way.bank_index[j]];
            end
        end
    end
endmodule

//--- hdl/plru_replace.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

module plru_replace (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        hit_en,
    input  logic [`ICACHE_SET_BITS-1:0] hit_set,
    input  logic [1:0]                  hit_way,
    input  logic                        miss_en,
    input  logic [`ICACHE_SET_BITS-1:0] miss_set,
    output logic [3:0]                  victim_way
);
    // bit 0 picks the pair, bit 1 the left pair, bit 2 the right pair
    logic [2:0] tree [`ICACHE_SETS];
    logic [2:0] miss_tree;
    logic [1:0] victim_idx;

    // point every node on the path away from the way just used
    function automatic logic [2:0] touch(input logic [2:0] t, input logic [1:0] w);
        logic [2:0] n;
        n = t;
        n[0] = ~w[1];
        if (w[1]) begin
            n[2] = ~w[0];
        end else begin
            n[1] = ~w[0];
        end
        return n;
    endfunction

    assign miss_tree  = tree[miss_set];
    assign victim_idx = miss_tree[0] ? {1'b1, miss_tree[2]} : {1'b0, miss_tree[1]};
    assign victim_way = 4'b0001 << victim_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree[s] <= 3'b000; // empty ways come out in order 0, 2, 1, 3
            end
        end else if (miss_en) begin
            tree[miss_set] <= touch(miss_tree, victim_idx); // fill counts as most recent
        end else if (hit_en) begin
            tree[hit_set] <= touch(tree[hit_set], hit_way);
        end
    end
endmodule

//--- hdl/icache.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    input  icache_pkg::fetch_addr_u              req_addr,
    input  logic [`ICACHE_WORD_BITS-1:0]         req_size,
    input  logic                                 flush,
    input  logic                                 mem_req_ready,
    input  logic                                 mem_resp_valid,
    input  logic [31:0]                          mem_resp_data,
    input  logic                                 mem_resp_last,
    output logic                                 req_ready,
    output logic                                 resp_valid,
    output logic [`ICACHE_FETCH_WORDS-1:0][31:0] resp_data,
    output logic [`ICACHE_FETCH_WORDS-1:0]       resp_mask,
    output logic [`ICACHE_ADDR_WIDTH-1:0]        resp_addr,
    output logic                                 mem_req_valid,
    output logic [`ICACHE_ADDR_WIDTH-1:0]        mem_req_addr,
    output logic [3:0]                           mem_req_len
);
    import icache_pkg::*;

    cache_state_t state;

    // request side, combinational from the incoming fetch
    logic                                         accept;
    logic [`ICACHE_WORD_BITS:0]                   end_word;
    logic [2*`ICACHE_LINE_WORDS-1:0]              expand;
    logic                                         span;
    logic [`ICACHE_SET_BITS:0]                    set_p1;   // carry marks the wrap to set 0
    logic [`ICACHE_FETCH_WORDS:0]                 mask_w;
    logic [`ICACHE_LINE_WORDS-1:0][`ICACHE_SET_BITS-1:0] bank_set;

    // registered request
    fetch_addr_u                                  rq_addr;
    logic [`ICACHE_FETCH_WORDS-1:0]               rq_mask;
    logic [2*`ICACHE_LINE_WORDS-1:0]              rq_expand;
    logic                                         rq_span;
    logic [`ICACHE_SET_BITS:0]                    rq_set_p1;
    logic                                         rq_wrap;
    logic [`ICACHE_SET_BITS-1:0]                  rq_set2;
    logic [`ICACHE_TAG_BITS-1:0]                  rq_tag2;

    // lookup
    logic [1:0][`ICACHE_WAYS-1:0]                 hit;
    logic [1:0]                                   hit_idx [2];
    logic [1:0]                                   miss;
    logic                                         all_hit;
    logic                                         miss_start;
    logic [`ICACHE_LINE_WORDS-1:0][31:0]          rdata_w [`ICACHE_WAYS];
    logic [`ICACHE_FETCH_WORDS-1:0][31:0]         rot_data;
    logic [3:0]                                   victim_way;

    // miss and refill
    logic [3:0]                                   victim;
    logic                                         cur_line; // 0 first line, 1 second line
    logic                                         pend2;    // second 8-word burst still owed
    logic [`ICACHE_WORD_BITS-1:0]                 word_cnt;
    logic                                         flushed;
    logic                                         miss_done;
    logic [`ICACHE_LINE_WORDS-1:0][31:0]          line_buf;
    logic [`ICACHE_LINE_WORDS-1:0][31:0]          wline;
    logic [`ICACHE_FETCH_WORDS-1:0][31:0]         blk;
    logic [`ICACHE_WORD_BITS:0]                   blk_pos;
    logic                                         refill_we;
    logic [`ICACHE_TAG_BITS-1:0]                  line_tag;
    logic [`ICACHE_SET_BITS-1:0]                  line_set;

    assign req_ready = !flush && (state == IDLE || (state == LOOKUP && all_hit));
    assign accept    = req_valid && req_ready;

    // block expansion over two lines
    assign end_word = {1'b0, req_addr.f.word} + {1'b0, req_size} + 1'b1;
    assign span     = end_word[`ICACHE_WORD_BITS] & (|end_word[`ICACHE_WORD_BITS-1:0]);
    assign expand   = ((16'd1 << end_word) - 16'd1) ^ ((16'd1 << req_addr.f.word) - 16'd1);
    assign set_p1   = {1'b0, req_addr.f.set} + 1'b1;
    assign mask_w   = (9'd2 << req_size) - 9'd1;

    always_comb begin
        for (int j = 0; j < `ICACHE_LINE_WORDS; j++) begin
            bank_set[j] = expand[j] ? req_addr.f.set : set_p1[`ICACHE_SET_BITS-1:0];
        end
    end

    assign rq_wrap = rq_set_p1[`ICACHE_SET_BITS];
    assign rq_set2 = rq_set_p1[`ICACHE_SET_BITS-1:0];
    assign rq_tag2 = rq_addr.f.tag + rq_wrap;

    assign line_tag = cur_line ? rq_tag2 : rq_addr.f.tag;
    assign line_set = cur_line ? rq_set2 : rq_addr.f.set;

    assign refill_we = state == REFILL && mem_resp_valid && word_cnt == 3'd7;

    always_comb begin
        wline = line_buf;
        wline[`ICACHE_LINE_WORDS-1] = mem_resp_data; // 8th word straight from the bus
    end

    icache_way_if way_if [`ICACHE_WAYS] ();

    for (genvar i = 0; i < `ICACHE_WAYS; i++) begin : g_way
        icache_way u_way (
            .clk   (clk),
            .reset (reset),
            .way   (way_if[i].way)
        );

        assign way_if[i].rd_en        = accept;
        assign way_if[i].tag_index[0] = req_addr.f.set;
        assign way_if[i].tag_index[1] = set_p1[`ICACHE_SET_BITS-1:0];
        assign way_if[i].bank_index   = bank_set;
        assign way_if[i].we           = refill_we & victim[i];
        assign way_if[i].windex       = line_set;
        assign way_if[i].wtag         = line_tag;
        assign way_if[i].wline        = wline;

        assign hit[0][i] = way_if[i].tagv[0][`ICACHE_TAG_BITS] &&
                           way_if[i].tagv[0][`ICACHE_TAG_BITS-1:0] == rq_addr.f.tag;
        assign hit[1][i] = way_if[i].tagv[1][`ICACHE_TAG_BITS] &&
                           way_if[i].tagv[1][`ICACHE_TAG_BITS-1:0] == rq_tag2;
        assign rdata_w[i] = way_if[i].rdata;
    end

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            hit_idx[k] = 2'd0;
            for (int i = 0; i < `ICACHE_WAYS; i++) begin
                if (hit[k][i]) begin
                    hit_idx[k] = 2'(i);
                end
            end
        end
    end

    assign miss[0]    = ~|hit[0];
    assign miss[1]    = rq_span & ~|hit[1];
    assign all_hit    = ~|miss;
    assign miss_start = state == LOOKUP && !all_hit && !flush;

    // word i of the block sits in bank (start + i) of line 0 or line 1
    always_comb begin
        logic [`ICACHE_WORD_BITS:0] pos;
        for (int i = 0; i < `ICACHE_FETCH_WORDS; i++) begin
            pos = {1'b0, rq_addr.f.word} + 4'(i);
            rot_data[i] = rdata_w[hit_idx[pos[`ICACHE_WORD_BITS]]][pos[`ICACHE_WORD_BITS-1:0]];
        end
    end

    plru_replace u_plru (
        .clk        (clk),
        .reset      (reset),
        .hit_en     (state == LOOKUP && all_hit),
        .hit_set    (rq_addr.f.set),
        .hit_way    (hit_idx[0]),
        .miss_en    (miss_start),
        .miss_set   (miss[0] ? rq_addr.f.set : rq_set2),
        .victim_way (victim_way)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cur_line  <= 1'b0;
            pend2     <= 1'b0;
            word_cnt  <= '0;
            flushed   <= 1'b0;
            miss_done <= 1'b0;
        end else begin
            miss_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (flush) begin
                        state <= IDLE;
                    end else if (!all_hit) begin
                        state    <= MISS;
                        cur_line <= ~miss[0];
                        pend2    <= miss[0] & miss[1] & rq_wrap; // tags differ, two bursts
                        word_cnt <= '0;
                        flushed  <= 1'b0;
                    end else if (!accept) begin
                        state <= IDLE;
                    end
                end
                MISS: begin
                    if (mem_req_ready) begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_resp_valid) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (word_cnt == 3'd7) begin
                            cur_line <= 1'b1;
                        end
                        if (mem_resp_last) begin
                            if (pend2) begin
                                state <= MISS;
                                pend2 <= 1'b0;
                            end else begin
                                state     <= IDLE;
                                miss_done <= ~flushed & ~flush;
                            end
                        end
                    end
                end
                default: state <= IDLE;
            endcase
            if (flush && (state == MISS || state == REFILL)) begin
                flushed <= 1'b1; // let the bursts finish, drop the response
            end
        end
    end

    assign blk_pos = {cur_line, word_cnt} - {1'b0, rq_addr.f.word};

    always_ff @(posedge clk) begin
        if (accept) begin
            rq_addr   <= req_addr;
            rq_mask   <= mask_w[`ICACHE_FETCH_WORDS-1:0];
            rq_expand <= expand;
            rq_span   <= span;
            rq_set_p1 <= set_p1;
        end
        if (miss_start) begin
            victim      <= victim_way;
            blk         <= rot_data; // keeps words of a line that did hit
            mem_req_len <= (miss[0] & miss[1] & ~rq_wrap) ? 4'd15 : 4'd7;
        end
        if (state == REFILL && mem_resp_valid) begin
            line_buf[word_cnt] <= mem_resp_data;
            if (rq_expand[{cur_line, word_cnt}]) begin
                blk[blk_pos[`ICACHE_WORD_BITS-1:0]] <= mem_resp_data;
            end
        end
    end

    assign mem_req_valid = state == MISS;
    assign mem_req_addr  = {line_tag, line_set, {(`ICACHE_WORD_BITS + 2){1'b0}}};

    assign resp_valid = (state == LOOKUP && all_hit && !flush) || miss_done;
    assign resp_data  = miss_done ? blk : rot_data;
    assign resp_mask  = rq_mask;
    assign resp_addr  = rq_addr.raw;
endmodule

//--- hdl/icache_top.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    input  logic [`ICACHE_ADDR_WIDTH-1:0]        req_addr,
    input  logic [`ICACHE_WORD_BITS-1:0]         req_size,
    input  logic                                 flush,
    input  logic                                 mem_req_ready,
    input  logic                                 mem_resp_valid,
    input  logic [31:0]                          mem_resp_data,
    input  logic                                 mem_resp_last,
    output logic                                 req_ready,
    output logic                                 resp_valid,
    output logic [`ICACHE_FETCH_WORDS-1:0][31:0] resp_data,
    output logic [`ICACHE_FETCH_WORDS-1:0]       resp_mask,
    output logic [`ICACHE_ADDR_WIDTH-1:0]        resp_addr,
    output logic                                 mem_req_valid,
    output logic [`ICACHE_ADDR_WIDTH-1:0]        mem_req_addr,
    output logic [3:0]                           mem_req_len
);
    import icache_pkg::*;

    icache u_icache (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (req_valid),
        .req_addr       (fetch_addr_u'(req_addr)), // raw word seen as tag/set/word
        .req_size       (req_size),
        .flush          (flush),
        .mem_req_ready  (mem_req_ready),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_last  (mem_resp_last),
        .req_ready      (req_ready),
        .resp_valid     (resp_valid),
        .resp_data      (resp_data),
        .resp_mask      (resp_mask),
        .resp_addr      (resp_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_len    (mem_req_len)
    );
endmodule

//--- verification/icache_props.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_props (
    input logic                          clk,
    input logic                          reset,
    input logic                          flush,
    input logic                          req_ready,
    input logic                          resp_valid,
    input logic                          mem_req_valid,
    input logic                          mem_req_ready,
    input logic [`ICACHE_ADDR_WIDTH-1:0] mem_req_addr,
    input icache_pkg::cache_state_t      state
);
    import icache_pkg::*;

    // burst request held until memory takes it
    a_mem_addr_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else $error("mem_req_addr changed before mem_req_ready");

    a_no_resp_after_flush: assert property (@(posedge clk) disable iff (reset)
        flush |=> !resp_valid)
        else $error("resp_valid high in the cycle after a flush");

    a_no_ready_in_miss: assert property (@(posedge clk) disable iff (reset)
        state == MISS |-> !req_ready)
        else $error("req_ready high while a burst is pending");
endmodule

bind icache icache_props u_props (
    .clk           (clk),
    .reset         (reset),
    .flush         (flush),
    .req_ready     (req_ready),
    .resp_valid    (resp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_req_addr  (mem_req_addr),
    .state         (state)
);

//--- verification/icache_tb.sv
`timescale 1ns/100ps
`include "icache_settings.svh"

module icache_tb;
    logic                                 clk = 1'b0;
    logic                                 reset = 1'b1;
    logic                                 req_valid = 1'b0;
    logic [`ICACHE_ADDR_WIDTH-1:0]        req_addr = '0;
    logic [`ICACHE_WORD_BITS-1:0]         req_size = '0;
    logic                                 flush = 1'b0;
    logic                                 mem_req_ready = 1'b0;
    logic                                 mem_resp_valid = 1'b0;
    logic [31:0]                          mem_resp_data = '0;
    logic                                 mem_resp_last = 1'b0;
    logic                                 req_ready;
    logic                                 resp_valid;
    logic [`ICACHE_FETCH_WORDS-1:0][31:0] resp_data;
    logic [`ICACHE_FETCH_WORDS-1:0]       resp_mask;
    logic [`ICACHE_ADDR_WIDTH-1:0]        resp_addr;
    logic                                 mem_req_valid;
    logic [`ICACHE_ADDR_WIDTH-1:0]        mem_req_addr;
    logic [3:0]                           mem_req_len;

    logic [31:0] p_addr [$];
    int          p_size [$];
    int          p_flush [$];   // cycle offset after acceptance, -1 for none
    int          p_bursts [$];
    int          p_words [$];
    int          p_mode [$];    // 1 streams with its neighbours

    int          errors = 0;
    int          checks = 0;
    int          bursts = 0;
    int          words = 0;
    int          beats_left = 0;
    int          gap = 0;
    logic [31:0] mem_waddr = '0;
    int          cycle = 0;
    int          cycle_limit = 200;

    icache_top uut (.*);

    always #20 clk = ~clk;

    // burst memory, word at word address w reads as w ^ 5a5a0000
    initial begin
        void'($urandom(99)); // fixed seed for the memory delays
        forever begin
            @(posedge clk);
            if (reset) begin
                mem_req_ready  <= 1'b0;
                mem_resp_valid <= 1'b0;
                mem_resp_last  <= 1'b0;
                beats_left     <= 0;
            end else if (beats_left > 0) begin
                mem_resp_valid <= 1'b1;
                mem_resp_data  <= mem_waddr ^ 32'h5a5a0000;
                mem_resp_last  <= beats_left == 1;
                mem_waddr      <= mem_waddr + 32'd1;
                beats_left     <= beats_left - 1;
            end else begin
                mem_resp_valid <= 1'b0;
                mem_resp_last  <= 1'b0;
                if (mem_req_valid && mem_req_ready) begin
                    mem_req_ready <= 1'b0;
                    mem_waddr     <= {2'b00, mem_req_addr[`ICACHE_ADDR_WIDTH-1:2]};
                    beats_left    <= int'(mem_req_len) + 1;
                    bursts        <= bursts + 1;
                    words         <= words + int'(mem_req_len) + 1;
                end else if (mem_req_valid) begin
                    if (gap == 0) begin
                        mem_req_ready <= 1'b1;
                    end else begin
                        gap <= gap - 1;
                    end
                end else begin
                    gap <= int'($urandom % 4); // 0 to 3 cycles before ready
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycle);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] mem_word(input logic [31:0] byte_addr, input int i);
        return ({2'b00, byte_addr[31:2]} + 32'(i)) ^ 32'h5a5a0000;
    endfunction

    task automatic report_test(input int idx, input bit ok);
        $display("test %0d addr %h size %0d: %s", idx, p_addr[idx], p_size[idx],
                 ok ? "ok" : "mismatch");
    endtask

    task automatic check_resp(input int idx);
        checks++;
        if (resp_addr !== p_addr[idx]) begin
            $display("error at %0t: test %0d resp_addr %h, expected %h",
                     $time, idx, resp_addr, p_addr[idx]);
            errors++;
        end
        for (int i = 0; i < `ICACHE_FETCH_WORDS; i++) begin
            if (resp_mask[i] !== (i <= p_size[idx])) begin
                $display("error at %0t: test %0d resp_mask %b wrong at bit %0d",
                         $time, idx, resp_mask, i);
                errors++;
            end
            if (i <= p_size[idx] && resp_data[i] !== mem_word(p_addr[idx], i)) begin
                $display("error at %0t: test %0d word %0d is %h, expected %h",
                         $time, idx, i, resp_data[i], mem_word(p_addr[idx], i));
                errors++;
            end
        end
    endtask

    task automatic run_single(input int idx);
        int  b0;
        int  w0;
        int  err0;
        int  cyc;
        int  resps;
        bit  done;
        b0 = bursts;
        w0 = words;
        err0 = errors;
        cyc = 0;
        resps = 0;
        done = 1'b0;
        req_valid <= 1'b1;
        req_addr  <= p_addr[idx];
        req_size  <= p_size[idx][`ICACHE_WORD_BITS-1:0];
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
        flush     <= p_flush[idx] == 0;
        while (!done) begin
            @(posedge clk);
            cyc++;
            flush <= p_flush[idx] == cyc;
            if (resp_valid) begin
                resps++;
                check_resp(idx);
            end
            done = req_ready; // back in idle
        end
        checks++;
        if (resps != (p_flush[idx] < 0 ? 1 : 0)) begin
            $display("error at %0t: test %0d gave %0d responses", $time, idx, resps);
            errors++;
        end
        if (p_bursts[idx] == 0 && p_flush[idx] < 0 && cyc != 1) begin
            $display("error at %0t: test %0d hit answered after %0d cycles, expected 1",
                     $time, idx, cyc);
            errors++;
        end
        if (bursts - b0 != p_bursts[idx] || words - w0 != p_words[idx]) begin
            $display("error at %0t: test %0d saw %0d bursts of %0d words, expected %0d of %0d",
                     $time, idx, bursts - b0, words - w0, p_bursts[idx], p_words[idx]);
            errors++;
        end
        report_test(idx, errors == err0);
    endtask

    // one request per cycle, each must hit
    task automatic run_stream(input int first, input int last);
        int b0;
        int err0;
        b0 = bursts;
        for (int k = first; k <= last + 1; k++) begin
            err0 = errors;
            req_valid <= k <= last;
            if (k <= last) begin
                req_addr <= p_addr[k];
                req_size <= p_size[k][`ICACHE_WORD_BITS-1:0];
            end
            @(posedge clk);
            if (k <= last && !req_ready) begin
                $display("test %0d was not accepted on the cycle after the one before", k);
                errors++;
            end
            if (k > first) begin
                checks++;
                if (!resp_valid) begin
                    $display("error at %0t: test %0d has no response one cycle after acceptance",
                             $time, k - 1);
                    errors++;
                end else begin
                    check_resp(k - 1);
                end
                report_test(k - 1, errors == err0);
            end
        end
        if (bursts != b0) begin
            $display("error at %0t: memory burst during back-to-back hits", $time);
            errors++;
        end
    endtask

    initial begin
        int          fd;
        int          idx;
        int          last;
        int          sz;
        int          fl;
        int          bu;
        int          wo;
        int          mo;
        logic [31:0] a;
        string       line;
        fd = $fopen("verification/icache_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open verification/icache_patterns.txt");
            $display("Test failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%h %d %d %d %d %d", a, sz, fl, bu, wo, mo) == 6) begin
                        p_addr.push_back(a);
                        p_size.push_back(sz);
                        p_flush.push_back(fl);
                        p_bursts.push_back(bu);
                        p_words.push_back(wo);
                        p_mode.push_back(mo);
                    end
                end
            end
            $fclose(fd);
            cycle_limit = 200 * (p_addr.size() + 1);

            repeat (5) @(posedge clk);
            reset <= 1'b0;
            @(posedge clk);
            checks++;
            if (req_ready !== 1'b1 || resp_valid !== 1'b0 || mem_req_valid !== 1'b0) begin
                $display("error at %0t: outputs after reset are not idle", $time);
                errors++;
            end

            idx = 0;
            while (idx < p_addr.size()) begin
                if (p_mode[idx] == 1) begin
                    last = idx;
                    while (last + 1 < p_addr.size() && p_mode[last + 1] == 1) begin
                        last++;
                    end
                    run_stream(idx, last);
                    idx = last + 1;
                end else begin
                    run_single(idx);
                    idx++;
                end
            end

            $display("%0d tests, %0d checks, %0d errors", p_addr.size(), checks, errors);
            if (errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end
endmodule

//--- verification/icache_patterns.txt
# addr(hex) size(words-1) flush(cycle offset after accept, -1 none) bursts words mode
# mode 1 lines are issued back to back and must all hit
00001000 3 -1 1 8 0
00001000 3 -1 0 0 0
00001058 7 -1 1 16 0
000011f0 7 -1 2 16 0
00001040 7 -1 0 0 1
00001064 2 -1 0 0 1
00001200 7 -1 0 0 1
000011f8 3 -1 0 0 1
000020a0 0 -1 1 8 0
000022a0 0 -1 1 8 0
000024a0 0 -1 1 8 0
000026a0 0 -1 1 8 0
000020a0 0 -1 0 0 0
000028a0 0 -1 1 8 0
000020a0 0 -1 0 0 0
000024a0 0 -1 0 0 0
000026a0 0 -1 0 0 0
000028a0 0 -1 0 0 0
000022a0 0 -1 1 8 0
000030c0 3 0 0 0 0
000030c0 3 2 1 8 0
000030c0 3 -1 0 0 0
000033e8 7 1 2 16 0
000033e8 7 -1 0 0 0

//--- icache.f
+incdir+include
hdl/icache_pkg.sv
hdl/icache_way_if.sv
hdl/icache_way.sv
hdl/plru_replace.sv
hdl/icache.sv
hdl/icache_top.sv
verification/icache_props.sv
verification/icache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f icache.f --top-module icache_tb -o icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/icache_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$log"; then
    exit 1
fi
exit 0
